/* flist.f */
source/turfio_pkg.sv
source/lane_ctrl_if.sv
source/cin_reg_front.sv
source/cin_lane.sv
source/cin_readback.sv
source/turfio_cin_top.sv
sim/turfio_cin_asserts.sv
sim/turfio_cin_tb.sv

/* run.sh */
#!/bin/sh
# build and run the CIN testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module turfio_cin_tb -f flist.f
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

out=$(./obj_dir/Vturfio_cin_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q '^\*\* PASS \*\*$'; then
    exit 0
fi
exit 1

/* sim/turfio_cin_tb.sv */
`timescale 1ns/1ps

module turfio_cin_tb
    import turfio_pkg::*;
();

    localparam int TMO = 200;
    localparam int N_INT = 16;

    typedef struct {
        string       name;
        bit          we;
        logic [11:0] adr;
        logic [31:0] wdat;
        logic [31:0] exp;
    } step_t;

    logic cin_clk_i, rst_i, req_i, we_i, ack_o;
    logic [ADDR_W-1:0] adr_i;
    logic [WORD_W-1:0] wdat_i, rdat_o;
    logic [NUM_LANES*NIBBLE_W-1:0] cin_i;
    logic [NUM_LANES*WORD_W-1:0] cin_response_o;
    logic [NUM_LANES-1:0] cin_valid_o;

    step_t steps [17];
    logic [31:0] lcg_state = 32'd83385;
    logic [2:0] nib_idx = '0;
    bit streams_on = 1'b0;
    bit [NUM_LANES-1:0] corrupt = '0;
    bit [NUM_LANES-1:0] aligned = '0;
    int passed = 0;
    int failed = 0;
    int mon_errors = 0;
    logic [31:0] rd;

    turfio_cin_top i_turfio_cin_top (.*);

    initial begin
        cin_clk_i = 1'b0;
        forever #20 cin_clk_i = ~cin_clk_i;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // training words go out most significant nibble first
    // lanes stay quiet until the reset values have been read
    always @(posedge cin_clk_i) begin
        logic [3:0] tn;
        logic [3:0] rn;
        tn = TRAIN_VALUE[(7 - nib_idx) * 4 +: 4];
        for (int g = 0; g < NUM_LANES; g++) begin
            lcg_state = lcg_next(lcg_state);
            rn = lcg_state[19:16];
            // corrupt nibble always differs from the training nibble
            if (rn == tn) rn = rn ^ 4'h1;
            if (!streams_on) begin
                cin_i[g*4 +: 4] <= 4'h0;
            end else begin
                cin_i[g*4 +: 4] <= corrupt[g] ? rn : tn;
            end
        end
        nib_idx <= nib_idx + 1'b1;
    end

    // aligned lanes must only present the training word
    always @(negedge cin_clk_i) begin
        for (int g = 0; g < NUM_LANES; g++) begin
            if (aligned[g] && cin_valid_o[g]) begin
                assert (cin_response_o[g*32 +: 32] == TRAIN_VALUE) else begin
                    $display("Error lane %0d response: expected %h, actual %h",
                             g, TRAIN_VALUE, cin_response_o[g*32 +: 32]);
                    mon_errors++;
                end
            end
        end
    end

    task automatic abort_timeout(input string what);
        $display("timeout while waiting for %s", what);
        $display("** FAIL **");
        $finish;
    endtask

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (exp === act) begin
            $display("%s: ok", name);
            passed++;
        end else begin
            $display("Error %s: expected %h, actual %h", name, exp, act);
            failed++;
        end
    endtask

    // four-phase access with every wait bounded
    task automatic reg_access(input bit we, input logic [11:0] adr, input logic [31:0] wd,
                              output logic [31:0] rdata);
        int n;
        @(posedge cin_clk_i);
        req_i <= 1'b1;
        we_i <= we;
        adr_i <= adr;
        wdat_i <= wd;
        for (n = 0; n < TMO && !ack_o; n++) @(negedge cin_clk_i);
        if (!ack_o) abort_timeout("ack high");
        rdata = rdat_o;
        @(posedge cin_clk_i);
        req_i <= 1'b0;
        for (n = 0; n < TMO && ack_o; n++) @(negedge cin_clk_i);
        if (ack_o) abort_timeout("ack low");
    endtask

    task automatic wait_valid(input int lane, input int count);
        int seen;
        int n;
        seen = 0;
        for (n = 0; n < count * 8 + 40 && seen < count; n++) begin
            @(negedge cin_clk_i);
            if (cin_valid_o[lane]) seen++;
        end
        if (seen < count) abort_timeout($sformatf("valid words on lane %0d", lane));
    endtask

    // slip one nibble at a time until the capture holds the training word
    task automatic align_lane(input int lane);
        logic [31:0] cap;
        logic [31:0] dummy;
        logic [11:0] base;
        base = 12'h800 | 12'(lane << 8);
        for (int t = 0; t <= 8; t++) begin
            reg_access(1'b0, base | 12'h0C0, '0, cap);
            if (cap == TRAIN_VALUE) break;
            if (t < 8) begin
                reg_access(1'b1, base | 12'h0C0, '0, dummy);
                wait_valid(lane, 2);
            end
        end
        check($sformatf("align lane %0d", lane), TRAIN_VALUE, cap);
        if (cap == TRAIN_VALUE) aligned[lane] = 1'b1;
    endtask

    initial begin
        int m0;
        steps = '{
            '{"reset global ctrl", 0, 12'h000, 0, 0},
            '{"reset lane0 ctrl", 0, 12'h800, 0, 0},
            '{"reset lane0 errcnt", 0, 12'h804, 0, 0},
            '{"reset lane0 capture", 0, 12'h8C0, 0, 0},
            '{"reset lane7 ctrl", 0, 12'hF00, 0, 0},
            '{"reset lane7 errcnt", 0, 12'hF04, 0, 0},
            '{"reset lane7 capture", 0, 12'hFC0, 0, 0},
            '{"unmapped global", 0, 12'h010, 0, 0},
            '{"unmapped lane", 0, 12'h808, 0, 0},
            '{"write offset", 1, 12'h000, 32'hFFFF_FDFF, 0},
            '{"read offset masked", 0, 12'h000, 0, 32'h0000_0500},
            '{"write lane2 bitslip rst", 1, 12'hA00, 32'hFFFF_FFFE, 0},
            '{"read lane2 ctrl", 0, 12'hA00, 0, 32'h2},
            '{"write lane2 local rst", 1, 12'hA00, 32'hFFFF_FFFD, 0},
            '{"read lane2 local rst", 0, 12'hA00, 0, 32'h1},
            '{"clear lane2 ctrl", 1, 12'hA00, 0, 0},
            '{"read lane2 ctrl cleared", 0, 12'hA00, 0, 0}
        };
        rst_i = 1'b1;
        req_i = 1'b0;
        we_i = 1'b0;
        adr_i = '0;
        wdat_i = '0;
        cin_i = '0;
        repeat (16) @(posedge cin_clk_i);
        rst_i <= 1'b0;

        // register table
        foreach (steps[i]) begin
            reg_access(steps[i].we, steps[i].adr, steps[i].wdat, rd);
            if (steps[i].we) $display("%s: done", steps[i].name);
            else check(steps[i].name, steps[i].exp, rd);
        end

        // start the nibble streams and let every shift register fill
        streams_on = 1'b1;
        wait_valid(0, 2);

        // align every lane while the monitor watches the lanes already aligned
        for (int g = 0; g < NUM_LANES; g++) align_lane(g);
        m0 = mon_errors;
        wait_valid(0, 4);
        check("aligned responses", 0, mon_errors);

        // error interval on a clean and a corrupt lane
        corrupt[7] = 1'b1;
        aligned[7] = 1'b0;
        wait_valid(7, 2);
        reg_access(1'b1, 12'h8E0, N_INT, rd);
        reg_access(1'b1, 12'hFE0, N_INT, rd);
        wait_valid(7, 2 * N_INT + 2);
        reg_access(1'b0, 12'h804, '0, rd);
        check("clean lane errcnt", 0, rd);
        reg_access(1'b0, 12'hF04, '0, rd);
        check("corrupt lane errcnt", N_INT, rd);

        // local reset of the corrupt lane clears its nonzero count
        reg_access(1'b1, 12'hF00, 32'h1, rd);
        // training stream again for the re-alignment
        corrupt[7] = 1'b0;
        reg_access(1'b0, 12'hFC0, '0, rd);
        check("local rst capture", 0, rd);
        reg_access(1'b0, 12'hF04, '0, rd);
        check("local rst errcnt", 0, rd);
        reg_access(1'b1, 12'hF00, 32'h0, rd);
        wait_valid(7, 2);
        align_lane(7);
        wait_valid(7, 4);
        check("monitor after realign", m0, mon_errors);

        $display("tests: %0d passed, %0d failed", passed, failed);
        if (failed == 0 && mon_errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

/* sim/turfio_cin_asserts.sv */
`timescale 1ns/1ps

module turfio_cin_asserts
    import turfio_pkg::*;
(
    input logic                 cin_clk_i,
    input logic                 rst_i,
    input logic                 req_i,
    input logic                 ack_o,
    input logic [NUM_LANES-1:0] cin_valid_o,
    input logic [OFFSET_W-1:0]  offset
);

    logic [OFFSET_W-1:0] offset_q;
    logic                offset_chg;

    // a new shared offset may legally shorten one word period
    always_ff @(posedge cin_clk_i) begin
        offset_q <= offset;
    end
    assign offset_chg = (offset != offset_q);

    // ack only answers a pending request
    ack_needs_req: assert property (@(posedge cin_clk_i) disable iff (rst_i)
        $rose(ack_o) |-> $past(req_i)) else $error("ack rose without req");

    // ack is only dropped once req has gone low
    ack_falls_late: assert property (@(posedge cin_clk_i) disable iff (rst_i)
        $fell(ack_o) |-> !$past(req_i)) else $error("ack fell while req high");

    // one word per eight nibbles at most
    for (genvar g = 0; g < NUM_LANES; g++) begin : g_valid
        valid_cadence: assert property (@(posedge cin_clk_i) disable iff (rst_i || offset_chg)
            cin_valid_o[g] |=> !cin_valid_o[g] [*7]) else $error("valid pulsed too soon");
    end

endmodule

bind turfio_cin_top turfio_cin_asserts u_asserts (.*);

/* source/turfio_cin_top.sv */
`timescale 1ns/1ps

module turfio_cin_top
    import turfio_pkg::*;
(
    input  logic                          cin_clk_i,
    input  logic                          rst_i,
    // four-phase register port
    input  logic                          req_i,
    input  logic                          we_i,
    input  logic [ADDR_W-1:0]             adr_i,
    input  logic [WORD_W-1:0]             wdat_i,
    output logic                          ack_o,
    output logic [WORD_W-1:0]             rdat_o,
    // deserialized nibbles, lane 0 in the low bits
    input  logic [NUM_LANES*NIBBLE_W-1:0] cin_i,
    // aligned words and their strobes
    output logic [NUM_LANES*WORD_W-1:0]   cin_response_o,
    output logic [NUM_LANES-1:0]          cin_valid_o
);

    logic [OFFSET_W-1:0] offset;
    logic [LANE_W-1:0]   rd_lane;
    logic [RSEL_W-1:0]   rd_reg;
    logic [WORD_W-1:0]   rd_data;

    // one control bundle per lane
    lane_ctrl_if lane_ctrl [NUM_LANES] ();

    cin_reg_front u_front (
        .cin_clk_i (cin_clk_i),
        .rst_i     (rst_i),
        .req_i     (req_i),
        .we_i      (we_i),
        .adr_i     (adr_i),
        .wdat_i    (wdat_i),
        .rd_data_i (rd_data),
        .ack_o     (ack_o),
        .rdat_o    (rdat_o),
        .offset_o  (offset),
        .rd_lane_o (rd_lane),
        .rd_reg_o  (rd_reg),
        .lane_o    (lane_ctrl)
    );

    for (genvar g = 0; g < NUM_LANES; g++) begin : g_lane
        cin_lane u_lane (
            .cin_clk_i (cin_clk_i),
            .rst_i     (rst_i),
            .cin_i     (cin_i[g*NIBBLE_W +: NIBBLE_W]),
            .offset_i  (offset),
            .ctrl_o    (lane_ctrl[g])
        );
    end

    cin_readback u_readback (
        .cin_clk_i      (cin_clk_i),
        .rst_i          (rst_i),
        .rd_lane_i      (rd_lane),
        .rd_reg_i       (rd_reg),
        .lane_i         (lane_ctrl),
        .rd_data_o      (rd_data),
        .cin_response_o (cin_response_o),
        .cin_valid_o    (cin_valid_o)
    );

endmodule

/* source/cin_readback.sv */
`timescale 1ns/1ps

module cin_readback
    import turfio_pkg::*;
(
    input  logic                          cin_clk_i,
    input  logic                          rst_i,
    input  logic [LANE_W-1:0]             rd_lane_i,
    input  logic [RSEL_W-1:0]             rd_reg_i,
    lane_ctrl_if.readback                 lane_i [NUM_LANES],
    output logic [WORD_W-1:0]             rd_data_o,
    output logic [NUM_LANES*WORD_W-1:0]   cin_response_o,
    output logic [NUM_LANES-1:0]          cin_valid_o
);

    // read data of every lane for the current select
    logic [WORD_W-1:0] lane_rd [NUM_LANES];

    for (genvar g = 0; g < NUM_LANES; g++) begin : g_lane
        // response word, no reset on the payload
        always_ff @(posedge cin_clk_i) begin
            cin_response_o[g*WORD_W +: WORD_W] <= lane_i[g].word;
        end

        // valid strobe
        always_ff @(posedge cin_clk_i) begin
            if (rst_i) begin
                cin_valid_o[g] <= 1'b0;
            end else begin
                cin_valid_o[g] <= lane_i[g].word_valid;
            end
        end

        // per-lane read mux, fields zero-extended
        always_comb begin
            lane_rd[g] = '0;
            case (rd_reg_i)
                RSEL_CTRL: begin
                    lane_rd[g][CTRL_LOCAL_RST_BIT] = lane_i[g].local_rst;
                    lane_rd[g][CTRL_BITSLIP_RST_BIT] = lane_i[g].bitslip_rst;
                end
                RSEL_ERRCNT:  lane_rd[g][ERRCNT_W-1:0] = lane_i[g].err_count;
                RSEL_CAPTURE: lane_rd[g] = lane_i[g].capture;
                default:      lane_rd[g] = '0;
            endcase
        end
    end

    // addressed lane
    assign rd_data_o = lane_rd[rd_lane_i];

endmodule

/* source/cin_lane.sv */
`timescale 1ns/1ps

module cin_lane
    import turfio_pkg::*;
(
    input  logic                cin_clk_i,
    input  logic                rst_i,
    input  logic [NIBBLE_W-1:0] cin_i,
    input  logic [OFFSET_W-1:0] offset_i,
    lane_ctrl_if.lane           ctrl_o
);

    // nibble history, newest nibble in the low end
    logic [WORD_W-1:0]     sreg;
    // nibble position within the word
    logic [OFFSET_W-1:0]   phase;
    // phase moved into its value this cycle
    // low after a slip so a held phase does not present twice
    logic                  phase_new;
    logic                  phase_rst;
    logic                  lane_clr;
    logic                  word_valid;
    logic                  word_err;
    logic [WORD_W-1:0]     capture_q;
    // interval bookkeeping
    logic [INTERVAL_W-1:0] word_cnt;
    logic [ERRCNT_W-1:0]   err_acc;
    logic [ERRCNT_W-1:0]   err_count_q;
    logic                  interval_end;

    // any reset sends the phase back to zero
    assign phase_rst = rst_i || ctrl_o.local_rst || ctrl_o.bitslip_rst;
    // bitslip reset leaves the data path alone
    assign lane_clr = rst_i || ctrl_o.local_rst;

    // shift in one nibble per cycle
    always_ff @(posedge cin_clk_i) begin
        if (lane_clr) begin
            sreg <= '0;
        end else begin
            sreg <= {sreg[WORD_W-NIBBLE_W-1:0], cin_i};
        end
    end

    // phase counter
    // bitslip freezes it for one cycle, moving the boundary one nibble
    always_ff @(posedge cin_clk_i) begin
        if (phase_rst) begin
            phase <= '0;
            phase_new <= 1'b0;
        end else begin
            phase_new <= !ctrl_o.bitslip;
            if (!ctrl_o.bitslip) begin
                phase <= phase + 1'b1;
            end
        end
    end

    // word boundary where the phase meets the shared offset
    assign word_valid = phase_new && (phase == offset_i);

    // compare against the training pattern
    assign word_err = (sreg != TRAIN_VALUE);

    // hold the most recent aligned word
    always_ff @(posedge cin_clk_i) begin
        if (lane_clr) begin
            capture_q <= '0;
        end else if (word_valid) begin
            capture_q <= sreg;
        end
    end

    // last word of the current interval
    assign interval_end = (word_cnt == INTERVAL_W'(ctrl_o.interval - 1'b1));

    // error counter
    // counts mismatched words over N words, then latches and restarts
    always_ff @(posedge cin_clk_i) begin
        if (lane_clr) begin
            word_cnt <= '0;
            err_acc <= '0;
            err_count_q <= '0;
        end else if (ctrl_o.interval_load) begin
            // new interval restarts counting, latched result stays
            word_cnt <= '0;
            err_acc <= '0;
        end else if (word_valid) begin
            if (interval_end) begin
                err_count_q <= err_acc + ERRCNT_W'(word_err);
                err_acc <= '0;
                word_cnt <= '0;
            end else begin
                err_acc <= err_acc + ERRCNT_W'(word_err);
                word_cnt <= word_cnt + 1'b1;
            end
        end
    end

    // status to readback
    assign ctrl_o.word = sreg;
    assign ctrl_o.word_valid = word_valid;
    assign ctrl_o.capture = capture_q;
    assign ctrl_o.err_count = err_count_q;

endmodule

/* source/cin_reg_front.sv */
`timescale 1ns/1ps

module cin_reg_front
    import turfio_pkg::*;
(
    input  logic                cin_clk_i,
    input  logic                rst_i,
    input  logic                req_i,
    input  logic                we_i,
    input  logic [ADDR_W-1:0]   adr_i,
    input  logic [WORD_W-1:0]   wdat_i,
    input  logic [WORD_W-1:0]   rd_data_i,
    output logic                ack_o,
    output logic [WORD_W-1:0]   rdat_o,
    output logic [OFFSET_W-1:0] offset_o,
    output logic [LANE_W-1:0]   rd_lane_o,
    output logic [RSEL_W-1:0]   rd_reg_o,
    lane_ctrl_if.front          lane_o [NUM_LANES]
);

    // idle, access cycle, then hold ack until req drops
    typedef enum logic [1:0] {ST_IDLE, ST_ACK, ST_WAIT} front_state_t;

    front_state_t              state;
    logic [ADDR_W-1:0]         adr_q;
    logic                      we_q;
    logic [WORD_W-1:0]         wdat_q;
    logic                      lane_space;
    logic [ADR_UPPER_BIT:0]    lane_ofs;
    logic                      wr_en;
    logic                      wr_global;
    logic                      wr_ctrl;
    logic                      wr_bitslip;
    logic                      wr_interval;
    logic [WORD_W-1:0]         global_rd;
    logic [WORD_W-1:0]         rd_value;

    // address fields of the latched access
    assign lane_space = adr_q[ADR_LANE_SPACE_BIT];
    assign lane_ofs = adr_q[ADR_UPPER_BIT:0];
    assign rd_lane_o = adr_q[ADR_LANE_LSB +: LANE_W];

    // writes take effect in the access cycle only
    assign wr_en = (state == ST_ACK) && we_q;
    assign wr_global = wr_en && (adr_q == REG_GLOBAL_CTRL);
    assign wr_ctrl = wr_en && lane_space && (lane_ofs == REG_LANE_CTRL);
    assign wr_bitslip = wr_en && lane_space && (lane_ofs == REG_LANE_CAPTURE);
    assign wr_interval = wr_en && lane_space && (lane_ofs == REG_LANE_INTERVAL);

    // lane register select for readback, unmapped offsets read zero
    always_comb begin
        rd_reg_o = RSEL_NONE;
        if (lane_space) begin
            case (lane_ofs)
                REG_LANE_CTRL:    rd_reg_o = RSEL_CTRL;
                REG_LANE_ERRCNT:  rd_reg_o = RSEL_ERRCNT;
                REG_LANE_CAPTURE: rd_reg_o = RSEL_CAPTURE;
                default:          rd_reg_o = RSEL_NONE;
            endcase
        end
    end

    // global space only holds the offset field
    always_comb begin
        global_rd = '0;
        if (adr_q == REG_GLOBAL_CTRL) begin
            global_rd[GLOBAL_OFFSET_LSB +: OFFSET_W] = offset_o;
        end
    end

    assign rd_value = lane_space ? rd_data_i : global_rd;

    // handshake: latch on req, access, then ack and wait for req low
    always_ff @(posedge cin_clk_i) begin
        if (rst_i) begin
            state <= ST_IDLE;
            ack_o <= 1'b0;
            rdat_o <= '0;
            adr_q <= '0;
            we_q <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: if (req_i) begin
                    adr_q <= adr_i;
                    we_q <= we_i;
                    state <= ST_ACK;
                end
                ST_ACK: state <= ST_WAIT;
                ST_WAIT: if (!ack_o) begin
                    ack_o <= 1'b1;
                    // writes return zero
                    rdat_o <= we_q ? '0 : rd_value;
                end else if (!req_i) begin
                    ack_o <= 1'b0;
                    state <= ST_IDLE;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge cin_clk_i) begin
        if (state == ST_IDLE && req_i) begin
            wdat_q <= wdat_i;
        end
    end

    // shared word offset
    always_ff @(posedge cin_clk_i) begin
        if (rst_i) begin
            offset_o <= '0;
        end else if (wr_global) begin
            offset_o <= wdat_q[GLOBAL_OFFSET_LSB +: OFFSET_W];
        end
    end

    // per-lane control registers
    for (genvar g = 0; g < NUM_LANES; g++) begin : g_lane
        logic                  hit;
        logic                  local_rst_q;
        logic                  bitslip_rst_q;
        logic                  bitslip_q;
        logic                  interval_load_q;
        logic [INTERVAL_W-1:0] interval_q;

        assign hit = (rd_lane_o == LANE_W'(g));

        always_ff @(posedge cin_clk_i) begin
            if (rst_i) begin
                local_rst_q <= 1'b0;
                bitslip_rst_q <= 1'b0;
                bitslip_q <= 1'b0;
                interval_load_q <= 1'b0;
                interval_q <= '0;
            end else begin
                // pulses last the cycle after the access
                bitslip_q <= wr_bitslip && hit;
                interval_load_q <= wr_interval && hit;
                if (wr_ctrl && hit) begin
                    local_rst_q <= wdat_q[CTRL_LOCAL_RST_BIT];
                    bitslip_rst_q <= wdat_q[CTRL_BITSLIP_RST_BIT];
                end
                if (wr_interval && hit) begin
                    interval_q <= wdat_q[INTERVAL_W-1:0];
                end
            end
        end

        assign lane_o[g].local_rst = local_rst_q;
        assign lane_o[g].bitslip_rst = bitslip_rst_q;
        assign lane_o[g].bitslip = bitslip_q;
        assign lane_o[g].interval_load = interval_load_q;
        assign lane_o[g].interval = interval_q;
    end

endmodule

/* source/lane_ctrl_if.sv */
`timescale 1ns/1ps

interface lane_ctrl_if
    import turfio_pkg::*;
();

    // controls from the register front end
    // levels
    logic                  local_rst;
    logic                  bitslip_rst;
    // single-cycle pulses
    logic                  bitslip;
    logic                  interval_load;
    // interval length in words, held by the front end
    logic [INTERVAL_W-1:0] interval;

    // status from the lane
    // word_valid marks the cycle in which word is aligned
    logic [WORD_W-1:0]     word;
    logic                  word_valid;
    logic [WORD_W-1:0]     capture;
    logic [ERRCNT_W-1:0]   err_count;

    modport front (output local_rst, bitslip_rst, bitslip, interval_load, interval);

    modport lane (
        input  local_rst, bitslip_rst, bitslip, interval_load, interval,
        output word, word_valid, capture, err_count
    );

    // readback sees the control levels too so they can be read back
    modport readback (input local_rst, bitslip_rst, word, word_valid, capture, err_count);

endinterface

/* source/turfio_pkg.sv */
package turfio_pkg;

    // lane geometry
    // eight cin lanes share one link clock
    localparam int NUM_LANES = 8;
    localparam int LANE_W = $clog2(NUM_LANES);

    // deserializer hands over one nibble per cycle
    localparam int NIBBLE_W = 4;
    localparam int NIBBLES_PER_WORD = 8;
    localparam int WORD_W = NIBBLE_W * NIBBLES_PER_WORD;

    // word offset and phase counter both count nibbles within a word
    localparam int OFFSET_W = $clog2(NIBBLES_PER_WORD);

    // bit error counting
    // interval is in words, count needs one extra bit to hold a full interval
    localparam int INTERVAL_W = 24;
    localparam int ERRCNT_W = 25;

    // training word the remote end sends while idle
    localparam logic [WORD_W-1:0] TRAIN_VALUE = 32'hA55A6996;

    // register port
    localparam int ADDR_W = 12;

    // address fields
    // bit 11 high selects lane space, bits 10:8 pick the lane
    localparam int ADR_LANE_SPACE_BIT = 11;
    localparam int ADR_LANE_LSB = 8;
    // top bit of the offset inside one lane
    localparam int ADR_UPPER_BIT = 7;

    // per-lane register offsets
    // control levels: local reset and bitslip reset
    localparam logic [ADR_UPPER_BIT:0] REG_LANE_CTRL = 8'h00;
    // latched bit error count, read only
    localparam logic [ADR_UPPER_BIT:0] REG_LANE_ERRCNT = 8'h04;
    // read gives the captured word, write slips one nibble
    localparam logic [ADR_UPPER_BIT:0] REG_LANE_CAPTURE = 8'hC0;
    // write loads the error interval and restarts counting
    localparam logic [ADR_UPPER_BIT:0] REG_LANE_INTERVAL = 8'hE0;

    // bit positions in the lane control register
    localparam int CTRL_LOCAL_RST_BIT = 0;
    localparam int CTRL_BITSLIP_RST_BIT = 1;

    // global space
    // the only global register holds the shared word offset
    localparam logic [ADDR_W-1:0] REG_GLOBAL_CTRL = 12'h000;
    localparam int GLOBAL_OFFSET_LSB = 8;

    // read select passed from the front end to readback
    localparam int RSEL_W = 2;
    localparam logic [RSEL_W-1:0] RSEL_NONE = 2'd0;
    localparam logic [RSEL_W-1:0] RSEL_CTRL = 2'd1;
    localparam logic [RSEL_W-1:0] RSEL_ERRCNT = 2'd2;
    localparam logic [RSEL_W-1:0] RSEL_CAPTURE = 2'd3;

endpackage
